/* AddCfast.sv */
`timescale 1ns/100ps
`default_nettype none

module AddCfast #(
	parameter int width = 8, // chunk width, at least 2
	parameter int speed = 2  // prefix structure
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	input  logic             CI, // carry in, late arriving
	output logic [width-1:0] S,  // A + B + CI
	output logic             CO  // carry out of the top bit
);

	logic [width-1:0] gBit; // bit generate
	logic [width-1:0] pBit; // bit propagate, or form
	logic [width-1:0] xBit; // xor propagate for the sum
	logic [width-1:0] gGrp; // carry out of bit i

	assign gBit = A & B;
	assign pBit = A | B;
	assign xBit = pBit & ~gBit; // same as A ^ B

	PrefixAndOrCfast #(
		.width(width),
		.speed(speed)
	) carryTree (
		.GI(gBit),
		.PI(pBit),
		.CI(CI),
		.GO(gGrp),
		.PO()       // group propagate not needed here
	);

	assign S  = xBit ^ {gGrp[width-2:0], CI}; // carry into bit i is gGrp[i-1]
	assign CO = gGrp[width-1];

endmodule

`default_nettype wire

/* AddPipeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module AddPipeStage #(
	parameter int chunkWidth = 8, // bits added in this stage
	parameter int speed      = 2, // prefix structure
	parameter int stageIdx   = 0  // chunk owned by this stage
) (
	input  logic            clk,
	input  logic            arstN,
	input  logic            validIn,  // operation strobe
	input  logic            sub,      // subtract level, low past stage 0
	input  adderPkg::word_t aIn,
	input  adderPkg::word_t bIn,
	input  adderPkg::word_t sumIn,    // chunks below stageIdx done
	input  logic            carryIn,  // carry from previous chunk
	output logic            validOut,
	output adderPkg::word_t aOut,
	output adderPkg::word_t bOut,     // already conditioned
	output adderPkg::word_t sumOut,   // chunks 0..stageIdx done
	output logic            carryOut, // carry out of this chunk
	output logic            ovfOut    // meaningful in the last stage only
);

	localparam int numStages = adderPkg::wordWidth / chunkWidth;
	localparam int lsb       = stageIdx * chunkWidth; // chunk base bit
	localparam int msb       = adderPkg::wordWidth - 1;
	localparam bit isFirst   = (stageIdx == 0);
	localparam bit isLast    = (stageIdx == numStages - 1);

	typedef logic [chunkWidth-1:0] chunk_t; // one stage's slice

	adderPkg::word_t bCond;   // b, inverted when subtracting
	adderPkg::word_t sumNext; // partial sum with this chunk merged
	chunk_t          chunkSum;
	logic            cIn;     // carry into the chunk adder
	logic            cOut;
	logic            ovfNext;

	assign bCond = bIn ^ {adderPkg::wordWidth{sub}}; // ones complement
	assign cIn   = isFirst ? sub : carryIn; // the +1 of a - b enters here

	AddCfast #(
		.width(chunkWidth),
		.speed(speed)
	) chunkAdder (
		.A (aIn[lsb +: chunkWidth]),
		.B (bCond[lsb +: chunkWidth]),
		.CI(cIn),
		.S (chunkSum),
		.CO(cOut)
	);

	always_comb begin
		sumNext = sumIn;
		sumNext[lsb +: chunkWidth] = chunkSum;
	end

	// operand signs agree but result sign flips
	assign ovfNext = isLast && (aIn[msb] == bCond[msb])
		&& (chunkSum[chunkWidth-1] != aIn[msb]);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validOut <= 1'b0;
			aOut     <= '0;
			bOut     <= '0;
			sumOut   <= '0;
			carryOut <= 1'b0;
			ovfOut   <= 1'b0;
		end else begin
			validOut <= validIn;
			if (validIn) begin // hold data between operations
				aOut     <= aIn;
				bOut     <= bCond;
				sumOut   <= sumNext;
				carryOut <= cOut;
				ovfOut   <= ovfNext;
			end
		end
	end

	// prefix tree result vs plain arithmetic, one edge later
	chunkSumMatch: assert property (@(posedge clk) disable iff (!arstN)
		validIn |=> {carryOut, sumOut[lsb +: chunkWidth]} ==
			{1'b0, $past(aIn[lsb +: chunkWidth])}
			+ $past(bCond[lsb +: chunkWidth]) + $past(cIn))
		else $error("stage %0d chunk sum mismatch", stageIdx);

	validKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(validOut))
		else $error("stage %0d validOut unknown", stageIdx);

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: wide_adder

sources:
  # design
  - adderPkg.sv
  - PrefixAndOr.sv
  - PrefixAndOrCfast.sv
  - AddCfast.sv
  - AddPipeStage.sv
  - WideAdderTop.sv
  # testbench
  - target: test
    files:
      - tbWideAdder.sv

/* PrefixAndOr.sv */
`timescale 1ns/100ps
`default_nettype none

module PrefixAndOr #(
	parameter int width = 8,                      // bits in the prefix
	parameter int speed = adderPkg::speedSklansky // structure select
) (
	input  logic [width-1:0] GI, // bit generate
	input  logic [width-1:0] PI, // bit propagate
	output logic [width-1:0] GO, // group generate over bits 0..i
	output logic [width-1:0] PO  // group propagate over bits 0..i
);

	localparam int n = width;         // nodes per level
	localparam int m = $clog2(width); // depth of a full binary tree

	if (speed == adderPkg::speedSerial) begin : serialPrefix
		logic [n-1:0] gT; // running generate
		logic [n-1:0] pT; // running propagate

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];
		for (genvar i = 1; i < n; i++) begin : chain
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]); // one and-or per bit
			assign pT[i] = PI[i] & pT[i-1];
		end
		assign GO = gT;
		assign PO = pT;

	end else if (speed == adderPkg::speedBrentKung) begin : bkPrefix
		logic [n-1:0] gT [0:2*m-1]; // level 0 is the input
		logic [n-1:0] pT [0:2*m-1];

		assign gT[0] = GI;
		assign pT[0] = PI;

		// up-sweep, top node of each group joins the top of its lower half
		for (genvar l = 1; l <= m; l++) begin : upLevel
			for (genvar k = 0; k < 2**(m-l); k++) begin : upGroup
				for (genvar j = 0; j < 2**l; j++) begin : upNode
					localparam int pos = k * 2**l + j;
					localparam int src = k * 2**l + 2**(l-1) - 1;
					if (pos < n) begin : node // pruned past width
						if (j == 2**l - 1) begin : black
							assign gT[l][pos] = gT[l-1][pos]
								| (pT[l-1][pos] & gT[l-1][src]);
							assign pT[l][pos] = pT[l-1][pos] & pT[l-1][src];
						end else begin : white
							assign gT[l][pos] = gT[l-1][pos];
							assign pT[l][pos] = pT[l-1][pos];
						end
					end
				end
			end
		end

		// down-sweep fills the mid points from the group below
		for (genvar l = m + 1; l < 2*m; l++) begin : downLevel
			localparam int span = 2**(2*m - l);
			for (genvar k = 0; k < 2**(l-m); k++) begin : downGroup
				for (genvar j = 0; j < span; j++) begin : downNode
					localparam int pos = k * span + j;
					localparam int src = k * span - 1; // last node of previous group
					if (pos < n) begin : node
						if (k > 0 && j == span/2 - 1) begin : black
							assign gT[l][pos] = gT[l-1][pos]
								| (pT[l-1][pos] & gT[l-1][src]);
							assign pT[l][pos] = pT[l-1][pos] & pT[l-1][src];
						end else begin : white
							assign gT[l][pos] = gT[l-1][pos];
							assign pT[l][pos] = pT[l-1][pos];
						end
					end
				end
			end
		end
		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];

	end else if (speed == adderPkg::speedSklansky) begin : skPrefix
		logic [n-1:0] gT [0:m];
		logic [n-1:0] pT [0:m];

		assign gT[0] = GI;
		assign pT[0] = PI;

		// upper half of every group joins the top bit of its lower half
		for (genvar l = 1; l <= m; l++) begin : skLevel
			for (genvar k = 0; k < 2**(m-l); k++) begin : skGroup
				for (genvar j = 0; j < 2**l; j++) begin : skNode
					localparam int pos = k * 2**l + j;
					localparam int src = k * 2**l + 2**(l-1) - 1; // fans out to half
					if (pos < n) begin : node
						if (j >= 2**(l-1)) begin : black
							assign gT[l][pos] = gT[l-1][pos]
								| (pT[l-1][pos] & gT[l-1][src]);
							assign pT[l][pos] = pT[l-1][pos] & pT[l-1][src];
						end else begin : white
							assign gT[l][pos] = gT[l-1][pos];
							assign pT[l][pos] = pT[l-1][pos];
						end
					end
				end
			end
		end
		assign GO = gT[m];
		assign PO = pT[m];

	end else begin : badSpeed
		$error("PrefixAndOr: unknown speed %0d", speed);
	end

endmodule

`default_nettype wire

/* PrefixAndOrCfast.sv */
`timescale 1ns/100ps
`default_nettype none

module PrefixAndOrCfast #(
	parameter int width = 8, // bits in the prefix
	parameter int speed = 2  // sklansky unless overridden
) (
	input  logic [width-1:0] GI, // bit generate
	input  logic [width-1:0] PI, // bit propagate
	input  logic             CI, // late carry in
	output logic [width-1:0] GO, // group generate incl. carry in
	output logic [width-1:0] PO  // group propagate
);

	logic [width-1:0] gT; // prefix result without carry
	logic [width-1:0] pT;

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) prefixCore (
		.GI(GI),
		.PI(PI),
		.GO(gT),
		.PO(pT)
	);

	// one extra and-or level, so CI never enters the tree
	assign GO = gT | (pT & {width{CI}});
	assign PO = pT;

endmodule

`default_nettype wire

/* WideAdderTop.sv */
`timescale 1ns/100ps
`default_nettype none

module WideAdderTop #(
	parameter int chunkWidth = 8,                      // must divide wordWidth
	parameter int speed      = adderPkg::speedSklansky // prefix structure
) (
	input  logic            clk,
	input  logic            arstN,
	input  logic            inValid,  // one operation per strobe
	input  logic            sub,      // sampled with inValid
	input  adderPkg::word_t a,
	input  adderPkg::word_t b,
	output logic            outValid, // numStages edges after inValid
	output adderPkg::word_t sum,
	output logic            carryOut, // not-borrow when subtracting
	output logic            overflow  // signed overflow
);

	localparam int numStages = adderPkg::wordWidth / chunkWidth;

	// index k feeds stage k, index k+1 is its output
	logic [numStages:0] validPipe;
	logic [numStages:0] carryPipe;
	logic [numStages:1] ovfPipe; // only the last one is read
	adderPkg::word_t    aPipe   [0:numStages];
	adderPkg::word_t    bPipe   [0:numStages];
	adderPkg::word_t    sumPipe [0:numStages];

	assign validPipe[0] = inValid;
	assign carryPipe[0] = 1'b0; // stage 0 takes sub as its carry
	assign aPipe[0]     = a;
	assign bPipe[0]     = b;
	assign sumPipe[0]   = '0;

	for (genvar k = 0; k < numStages; k++) begin : stageGen
		AddPipeStage #(
			.chunkWidth(chunkWidth),
			.speed     (speed),
			.stageIdx  (k)
		) stage (
			.clk     (clk),
			.arstN   (arstN),
			.validIn (validPipe[k]),
			.sub     ((k == 0) ? sub : 1'b0), // b is conditioned once
			.aIn     (aPipe[k]),
			.bIn     (bPipe[k]),
			.sumIn   (sumPipe[k]),
			.carryIn (carryPipe[k]),
			.validOut(validPipe[k+1]),
			.aOut    (aPipe[k+1]),
			.bOut    (bPipe[k+1]),
			.sumOut  (sumPipe[k+1]),
			.carryOut(carryPipe[k+1]),
			.ovfOut  (ovfPipe[k+1])
		);
	end

	assign outValid = validPipe[numStages];
	assign sum      = sumPipe[numStages];
	assign carryOut = carryPipe[numStages];
	assign overflow = ovfPipe[numStages];

endmodule

`default_nettype wire

/* adderPkg.sv */
`default_nettype none

package adderPkg;

	localparam int wordWidth = 32; // operand and result width

	typedef logic [wordWidth-1:0] word_t; // operands, partial sums, result

	// prefix structure select
	localparam int speedSerial    = 0; // ripple chain, smallest
	localparam int speedBrentKung = 1; // up-sweep plus down-sweep tree
	localparam int speedSklansky  = 2; // log depth, high fan-out

endpackage

`default_nettype wire

/* filelist.f */
adderPkg.sv
PrefixAndOr.sv
PrefixAndOrCfast.sv
AddCfast.sv
AddPipeStage.sv
WideAdderTop.sv
tbWideAdder.sv

/* tbWideAdder.sv */
`timescale 1ns/100ps
`default_nettype none

module tbWideAdder;

	localparam int chunkWidth   = 8;
	localparam int numStages    = adderPkg::wordWidth / chunkWidth;
	localparam int msb          = adderPkg::wordWidth - 1;
	localparam int stimCycles   = 680; // about 500 operations at 3/4 load
	localparam int timeoutLimit = 2 * stimCycles + numStages + 20;
	localparam adderPkg::word_t chunkOnes = (1 << chunkWidth) - 1;

	logic            clk;
	logic            arstN;
	logic            inValid;
	logic            sub;
	adderPkg::word_t a;
	adderPkg::word_t b;
	logic            outValid;
	adderPkg::word_t sum;
	logic            carryOut;
	logic            overflow;

	logic [31:0]     lcgState = 32'h85d2_8e26;
	int              cycleCount = 0;
	int              errorCount = 0;

	// model queues, one entry per operation in flight
	adderPkg::word_t expSumQ   [$];
	logic            expCarryQ [$];
	logic            expOvfQ   [$];
	int              ageQ      [$]; // falling edges since the push

	WideAdderTop #(
		.chunkWidth(chunkWidth),
		.speed     (adderPkg::speedBrentKung)
	) WideAdderTop_inst (
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.sub     (sub),
		.a       (a),
		.b       (b),
		.outValid(outValid),
		.sum     (sum),
		.carryOut(carryOut),
		.overflow(overflow)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	initial begin
		wait (cycleCount >= timeoutLimit);
		$display("Timeout: the DUT did not finish within %0d cycles", timeoutLimit);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped by the cycle limit");
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// low lcg bits are weak, so only upper halves are used
	function automatic adderPkg::word_t randomWord();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = nextRandom();
		lo = nextRandom();
		return {hi[31:16], lo[31:16]};
	endfunction

	task automatic compareValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic pushModel(input adderPkg::word_t x, input adderPkg::word_t y,
		input logic s);
		logic [adderPkg::wordWidth:0] full; // one bit above the word
		logic                         ov;
		if (s) begin
			full = {1'b0, x} + {1'b0, ~y} + 1'b1; // two's complement subtract
			ov   = (x[msb] != y[msb]) && (full[msb] != x[msb]);
		end else begin
			full = {1'b0, x} + {1'b0, y};
			ov   = (x[msb] == y[msb]) && (full[msb] != x[msb]); // same signs, sign flips
		end
		expSumQ.push_back(full[msb:0]);
		expCarryQ.push_back(full[adderPkg::wordWidth]);
		expOvfQ.push_back(ov);
		ageQ.push_back(0);
	endtask

	// outputs settled since the last rising edge
	task automatic checkOutputs();
		logic headDue;
		for (int i = 0; i < ageQ.size(); i++) ageQ[i]++;
		headDue = (ageQ.size() != 0) && (ageQ[0] == numStages); // exact latency
		compareValue("outValid", outValid, headDue);
		if (outValid) begin
			compareValue("sum", sum, expSumQ[0]);
			compareValue("carryOut", carryOut, expCarryQ[0]);
			compareValue("overflow", overflow, expOvfQ[0]);
			void'(expSumQ.pop_front());
			void'(expCarryQ.pop_front());
			void'(expOvfQ.pop_front());
			void'(ageQ.pop_front());
		end
	endtask

	task automatic driveNext();
		adderPkg::word_t sel;
		adderPkg::word_t opA;
		adderPkg::word_t opB;
		logic            opSub;
		int              shift;
		sel   = randomWord();
		opA   = randomWord();
		opB   = randomWord();
		opSub = sel[0];
		shift = (int'(sel[7:4]) % numStages) * chunkWidth; // chosen chunk base
		case (sel[11:8])
			4'd0: begin // all ones plus one ripples through every stage
				opA   = '1;
				opB   = 1;
				opSub = 1'b0;
			end
			4'd1: begin // zero minus one, borrow everywhere
				opA   = '0;
				opB   = 1;
				opSub = 1'b1;
			end
			4'd2: begin
				opA = chunkOnes << shift; // carry out of one chunk only
				opB = adderPkg::word_t'(1) << shift;
			end
			4'd3: begin
				opA = 32'h7fff_ffff; // most positive
				opB = sel[1] ? 32'h7fff_ffff : 32'hffff_ffff;
			end
			4'd4: begin
				opA = 32'h8000_0000; // most negative
				opB = sel[1] ? 32'h8000_0000 : 32'h0000_0001;
			end
			default: ; // plain random operands
		endcase
		inValid = (sel[13:12] != 2'b00); // gaps on a quarter of the cycles
		sub     = opSub;
		a       = opA;
		b       = opB;
		if (inValid) pushModel(opA, opB, opSub);
	endtask

	initial begin
		arstN   = 1'b0;
		inValid = 1'b0;
		sub     = 1'b0;
		a       = '0;
		b       = '0;

		// two rising edges in reset, outValid must stay low
		repeat (2) begin
			@(negedge clk);
			checkOutputs();
		end
		arstN = 1'b1;

		for (int i = 0; i < stimCycles; i++) begin
			@(negedge clk);
			checkOutputs();
			driveNext();
		end

		@(negedge clk);
		checkOutputs();
		inValid = 1'b0;
		while (ageQ.size() != 0) begin // drain, timeout guards this
			@(negedge clk);
			checkOutputs();
		end
		repeat (numStages + 2) begin // nothing spurious after the drain
			@(negedge clk);
			checkOutputs();
		end

		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
